/* source/int_exec_pkg.sv */
// ======================================
// Integer execution unit shared types
// ALU and opcode enums, decoded record,
// AXI4-Lite bundles and the address map
// ======================================

package int_exec_pkg;

  // ======================================
  // Bus and address map
  // ======================================
  localparam int AXIL_ADDR_W = 12;

  // Command register, write only
  localparam logic [AXIL_ADDR_W-1:0] ADDR_INSTR    = 12'h000;
  // Retired counter, read only
  localparam logic [AXIL_ADDR_W-1:0] ADDR_RETIRED  = 12'h004;
  // Register n at base plus 4n
  localparam logic [AXIL_ADDR_W-1:0] ADDR_REG_BASE = 12'h080;

  // ======================================
  // Enums
  // ======================================
  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_AND, ALU_OR,
    ALU_XOR, ALU_NOR, ALU_SL, ALU_SR, ALU_LUI
  } alu_op_e;

  // Instruction opcodes, codes 21 and up are illegal
  typedef enum logic [5:0] {
    OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
    OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_ADDI, OP_SLTI, OP_SLTUI,
    OP_ANDI, OP_ORI, OP_XORI, OP_SLLI, OP_SRLI, OP_SRAI, OP_LUI
  } opcode_e;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // ======================================
  // Structs
  // ======================================
  // Decoder output record
  typedef struct packed {
    alu_op_e     alu_op;
    logic        unsigned_op;
    logic        use_imm;
    logic [31:0] imm32;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic        illegal;
  } decoded_instr_t;

  // Master to slave
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    resp_e       bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    resp_e       rresp;
  } axil_rsp_t;

endpackage

/* source/alu.sv */
// ======================================
// Arithmetic-logic unit
// Pure combinational, one op per cycle
// ======================================

`timescale 1ns/1ns

module alu (
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  input  int_exec_pkg::alu_op_e alu_op,
  input  logic                  unsigned_op,
  output logic [31:0]           c
);

  // Shift amount from the low bits of b
  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      int_exec_pkg::ALU_ADD : c = a + b;
      int_exec_pkg::ALU_SUB : c = a - b;
      int_exec_pkg::ALU_SLT : begin
        // Result is 0 or 1
        c = 32'd0;
        if (unsigned_op) begin
          c[0] = (a < b);
        end else begin
          c[0] = ($signed(a) < $signed(b));
        end
      end
      int_exec_pkg::ALU_AND : c = a & b;
      int_exec_pkg::ALU_OR  : c = a | b;
      int_exec_pkg::ALU_XOR : c = a ^ b;
      int_exec_pkg::ALU_NOR : c = ~(a | b);
      int_exec_pkg::ALU_SL  : c = a << shamt;
      int_exec_pkg::ALU_SR  : begin
        // Logical for SRL, sign fill for SRA
        if (unsigned_op) begin
          c = a >> shamt;
        end else begin
          c = $unsigned($signed(a) >>> shamt);
        end
      end
      // Upper immediate already placed by the decoder
      int_exec_pkg::ALU_LUI : c = b;
      default : c = 32'd0;
    endcase
  end

endmodule

/* source/instr_decoder.sv */
// ======================================
// Instruction decoder
// Opcode to ALU op, immediate extension,
// illegal opcode flag
// ======================================

`timescale 1ns/1ns

module instr_decoder (
  input  logic [31:0]                  instr,
  output int_exec_pkg::decoded_instr_t dec
);

  int_exec_pkg::opcode_e opcode;

  // Immediate forms
  logic [31:0] imm_sext12;
  logic [31:0] imm_zext12;
  logic [31:0] imm_shamt;
  logic [31:0] imm_upper;

  assign opcode = int_exec_pkg::opcode_e'(instr[31:26]);

  assign imm_sext12 = {{20{instr[21]}}, instr[21:10]};
  assign imm_zext12 = {20'd0, instr[21:10]};
  assign imm_shamt  = {27'd0, instr[14:10]};
  assign imm_upper  = {instr[25:10], 16'd0};

  always_comb begin
    // Register fields always come from fixed positions
    dec.rd          = instr[4:0];
    dec.rj          = instr[9:5];
    dec.rk          = instr[14:10];
    dec.alu_op      = int_exec_pkg::ALU_ADD;
    dec.unsigned_op = 1'b0;
    dec.use_imm     = 1'b0;
    dec.imm32       = 32'd0;
    dec.illegal     = 1'b0;

    case (opcode)
      // Three-register forms
      int_exec_pkg::OP_ADD  : dec.alu_op = int_exec_pkg::ALU_ADD;
      int_exec_pkg::OP_SUB  : dec.alu_op = int_exec_pkg::ALU_SUB;
      int_exec_pkg::OP_SLT  : dec.alu_op = int_exec_pkg::ALU_SLT;
      int_exec_pkg::OP_SLTU : begin
        dec.alu_op      = int_exec_pkg::ALU_SLT;
        dec.unsigned_op = 1'b1;
      end
      int_exec_pkg::OP_AND  : dec.alu_op = int_exec_pkg::ALU_AND;
      int_exec_pkg::OP_OR   : dec.alu_op = int_exec_pkg::ALU_OR;
      int_exec_pkg::OP_XOR  : dec.alu_op = int_exec_pkg::ALU_XOR;
      int_exec_pkg::OP_NOR  : dec.alu_op = int_exec_pkg::ALU_NOR;
      int_exec_pkg::OP_SLL  : dec.alu_op = int_exec_pkg::ALU_SL;
      int_exec_pkg::OP_SRL  : begin
        dec.alu_op      = int_exec_pkg::ALU_SR;
        dec.unsigned_op = 1'b1;
      end
      int_exec_pkg::OP_SRA  : dec.alu_op = int_exec_pkg::ALU_SR;
      // Immediate forms, sign extended
      int_exec_pkg::OP_ADDI, int_exec_pkg::OP_SLTI, int_exec_pkg::OP_SLTUI : begin
        dec.use_imm     = 1'b1;
        dec.imm32       = imm_sext12;
        dec.alu_op      = (opcode == int_exec_pkg::OP_ADDI) ? int_exec_pkg::ALU_ADD
                                                            : int_exec_pkg::ALU_SLT;
        dec.unsigned_op = (opcode == int_exec_pkg::OP_SLTUI);
      end
      // Logic immediates, zero extended
      int_exec_pkg::OP_ANDI, int_exec_pkg::OP_ORI, int_exec_pkg::OP_XORI : begin
        dec.use_imm = 1'b1;
        dec.imm32   = imm_zext12;
        dec.alu_op  = (opcode == int_exec_pkg::OP_ANDI) ? int_exec_pkg::ALU_AND :
                      (opcode == int_exec_pkg::OP_ORI)  ? int_exec_pkg::ALU_OR
                                                        : int_exec_pkg::ALU_XOR;
      end
      // Shift amount in the rk field
      int_exec_pkg::OP_SLLI, int_exec_pkg::OP_SRLI, int_exec_pkg::OP_SRAI : begin
        dec.use_imm     = 1'b1;
        dec.imm32       = imm_shamt;
        dec.alu_op      = (opcode == int_exec_pkg::OP_SLLI) ? int_exec_pkg::ALU_SL
                                                            : int_exec_pkg::ALU_SR;
        dec.unsigned_op = (opcode == int_exec_pkg::OP_SRLI);
      end
      int_exec_pkg::OP_LUI  : begin
        dec.use_imm = 1'b1;
        dec.imm32   = imm_upper;
        dec.alu_op  = int_exec_pkg::ALU_LUI;
      end
      default : dec.illegal = 1'b1;
    endcase
  end

endmodule

/* source/reg_file.sv */
// ======================================
// 32 x 32 register file
// Zero register, two operand reads,
// host read, one write port
// ======================================

`timescale 1ns/1ns

module reg_file (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  rj_addr,
  input  logic [4:0]  rk_addr,
  input  logic [4:0]  host_addr,
  input  logic        we,
  input  logic [4:0]  wd_addr,
  input  logic [31:0] wd_data,
  output logic [31:0] rj_data,
  output logic [31:0] rk_data,
  output logic [31:0] host_data
);

  logic [31:0] regs [32];

  // All entries start at zero and r0 is never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we && (wd_addr != 5'd0)) begin
      regs[wd_addr] <= wd_data;
    end
  end

  // Combinational reads
  assign rj_data   = regs[rj_addr];
  assign rk_data   = regs[rk_addr];
  assign host_data = regs[host_addr];

endmodule

/* source/exec_pipe.sv */
// ======================================
// Two-stage execute pipe
// Operand latch, then ALU and write-back
// Counts retired instructions
// ======================================

`timescale 1ns/1ns

module exec_pipe #(
  parameter int RETIRED_W = 32
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         issue_valid,
  input  int_exec_pkg::decoded_instr_t dec,
  input  logic [31:0]                  rj_data,
  input  logic [31:0]                  rk_data,
  output logic                         busy,
  output logic                         we,
  output logic [4:0]                   wd_addr,
  output logic [31:0]                  wd_data,
  output logic [RETIRED_W-1:0]         retired
);

  // ======================================
  // Stage one, operand latch
  // ======================================
  logic                  s1_valid;
  logic [31:0]           s1_a;
  logic [31:0]           s1_b;
  logic [4:0]            s1_rd;
  int_exec_pkg::alu_op_e s1_alu_op;
  logic                  s1_unsigned;

  // Valid bit only, one instruction in flight at most
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  // Operand b is immediate or rk
  always_ff @(posedge clk) begin
    if (issue_valid) begin
      s1_a        <= rj_data;
      s1_b        <= dec.use_imm ? dec.imm32 : rk_data;
      s1_rd       <= dec.rd;
      s1_alu_op   <= dec.alu_op;
      s1_unsigned <= dec.unsigned_op;
    end
  end

  // ======================================
  // Stage two, execute and write-back
  // ======================================
  alu u_alu (
    .a           (s1_a),
    .b           (s1_b),
    .alu_op      (s1_alu_op),
    .unsigned_op (s1_unsigned),
    .c           (wd_data)
  );

  // Register file writes at the end of this cycle
  assign we      = s1_valid;
  assign wd_addr = s1_rd;
  // Stalls the bus slave for the write-back cycle
  assign busy    = s1_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retired <= '0;
    end else if (s1_valid) begin
      retired <= retired + 1'b1;
    end
  end

endmodule

/* source/axi_lite_slave_port.sv */
// ======================================
// AXI4-Lite slave port
// Instruction writes to the command reg,
// register file and counter reads
// ======================================

`timescale 1ns/1ns

module axi_lite_slave_port #(
  parameter int RETIRED_W = 32
) (
  input  logic                        clk,
  input  logic                        arst_n,
  input  int_exec_pkg::axil_req_t     req,
  output int_exec_pkg::axil_rsp_t     rsp,
  input  logic                        illegal,
  input  logic                        busy,
  output logic                        issue_valid,
  output logic [31:0]                 instr,
  output logic [4:0]                  host_addr,
  input  logic [31:0]                 host_data,
  input  logic [RETIRED_W-1:0]        retired
);

  // Handshake qualifiers
  logic wr_accept;
  logic rd_accept;
  logic wr_to_instr;

  // Read address decode
  logic [int_exec_pkg::AXIL_ADDR_W-1:0] reg_off;
  logic rd_is_reg;
  logic rd_is_retired;

  // Response holding registers
  logic                bvalid_q;
  int_exec_pkg::resp_e bresp_q;
  logic                rvalid_q;
  logic [31:0]         rdata_q;
  int_exec_pkg::resp_e rresp_q;

  // ======================================
  // Write channel
  // ======================================
  // AW and W taken together unless B is pending or the pipe is busy
  assign wr_accept   = req.awvalid && req.wvalid && !bvalid_q && !busy;
  assign wr_to_instr = (req.awaddr == int_exec_pkg::ADDR_INSTR);

  // Word goes straight to the decoder
  assign instr = req.wdata;

  // One-cycle issue in the accept cycle
  assign issue_valid = wr_accept && wr_to_instr && !illegal;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
    end else if (req.bready) begin
      // Held until the master takes it
      bvalid_q <= 1'b0;
    end
  end

  // Response code captured with the write
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp_q <= (wr_to_instr && !illegal) ? int_exec_pkg::RESP_OKAY
                                           : int_exec_pkg::RESP_SLVERR;
    end
  end

  // ======================================
  // Read channel
  // ======================================
  assign rd_accept = req.arvalid && !rvalid_q && !busy;

  // Offset into the register window
  assign reg_off       = req.araddr - int_exec_pkg::ADDR_REG_BASE;
  assign rd_is_retired = (req.araddr == int_exec_pkg::ADDR_RETIRED);
  // 32 aligned words from the base up
  assign rd_is_reg     = (reg_off[11:7] == 5'd0) && (reg_off[1:0] == 2'b00);

  // Word index for the host read port
  assign host_addr = reg_off[6:2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read data picked at accept and held while rvalid is high
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      if (rd_is_retired) begin
        rdata_q <= 32'(retired);
        rresp_q <= int_exec_pkg::RESP_OKAY;
      end else if (rd_is_reg) begin
        rdata_q <= host_data;
        rresp_q <= int_exec_pkg::RESP_OKAY;
      end else begin
        // Unmapped address
        rdata_q <= 32'd0;
        rresp_q <= int_exec_pkg::RESP_SLVERR;
      end
    end
  end

  // ======================================
  // Response bundle
  // ======================================
  always_comb begin
    rsp.awready = wr_accept;
    rsp.wready  = wr_accept;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = bresp_q;
    rsp.arready = rd_accept;
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
  end

endmodule

/* source/int_exec_unit.sv */
// ======================================
// Integer execution unit top level
// AXI4-Lite slave, decoder, register
// file and execute pipe
// ======================================

`timescale 1ns/1ns

module int_exec_unit #(
  parameter int RETIRED_W = 32
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  int_exec_pkg::axil_req_t axil_req,
  output int_exec_pkg::axil_rsp_t axil_rsp
);

  // Issue path
  logic                         issue_valid;
  logic [31:0]                  instr;
  int_exec_pkg::decoded_instr_t dec;
  logic                         busy;

  // Register file ports
  logic [31:0]          rj_data;
  logic [31:0]          rk_data;
  logic [4:0]           host_addr;
  logic [31:0]          host_data;
  logic                 we;
  logic [4:0]           wd_addr;
  logic [31:0]          wd_data;
  logic [RETIRED_W-1:0] retired;

  axi_lite_slave_port #(
    .RETIRED_W (RETIRED_W)
  ) u_axil (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (axil_req),
    .rsp         (axil_rsp),
    .illegal     (dec.illegal),
    .busy        (busy),
    .issue_valid (issue_valid),
    .instr       (instr),
    .host_addr   (host_addr),
    .host_data   (host_data),
    .retired     (retired)
  );

  instr_decoder u_dec (
    .instr (instr),
    .dec   (dec)
  );

  // Operand reads addressed by the decoded fields
  reg_file u_rf (
    .clk       (clk),
    .arst_n    (arst_n),
    .rj_addr   (dec.rj),
    .rk_addr   (dec.rk),
    .host_addr (host_addr),
    .we        (we),
    .wd_addr   (wd_addr),
    .wd_data   (wd_data),
    .rj_data   (rj_data),
    .rk_data   (rk_data),
    .host_data (host_data)
  );

  exec_pipe #(
    .RETIRED_W (RETIRED_W)
  ) u_pipe (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .dec         (dec),
    .rj_data     (rj_data),
    .rk_data     (rk_data),
    .busy        (busy),
    .we          (we),
    .wd_addr     (wd_addr),
    .wd_data     (wd_data),
    .retired     (retired)
  );

endmodule

/* bench/int_exec_unit_tb.sv */
// ======================================
// Integer execution unit testbench
// Drives instructions and reads over
// AXI4-Lite and checks a register model
// ======================================

`timescale 1ns/1ns

module int_exec_unit_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 1;

  // ======================================
  // Test lengths and watchdog budget
  // ======================================
  localparam int N_RRR_ITER = 4;
  localparam int N_IMM_ITER = 3;
  localparam int N_BP_INSTR = 24;
  localparam int N_TRANS    = 33 + 24 + 22 * N_RRR_ITER + 20 * N_IMM_ITER + 3 + 2
                              + 9 + 33 + N_BP_INSTR + 33;
  localparam int WATCHDOG_NS = (RESET_CYCLES + N_TRANS * 40) * CLK_PERIOD;

  logic                    clk;
  logic                    arst_n;
  int_exec_pkg::axil_req_t axil_req;
  int_exec_pkg::axil_rsp_t axil_rsp;

  // Reference model state
  logic [31:0] model_regs [32];
  int          model_retired;
  int          seed;
  // Largest random B or R stall in cycles
  int          max_stall;

  int_exec_unit #(
    .RETIRED_W (32)
  ) DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ======================================
  // Checking and random helpers
  // ======================================
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  function automatic int pick_stall();
    return (max_stall > 0) ? rand_range(0, max_stall) : 0;
  endfunction

  // Instruction word builders
  function automatic logic [31:0] make_rrr(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk);
    return {op, 11'd0, rk, rj, rd};
  endfunction

  function automatic logic [31:0] make_imm(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [15:0] imm);
    return {op, imm, rj, rd};
  endfunction

  // ======================================
  // Reference model of one instruction
  // ======================================
  function automatic logic [31:0] model_result(input logic [31:0] word);
    logic [5:0]  op;
    logic [31:0] a;
    logic [31:0] bk;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [4:0]  shi;
    logic [31:0] r;
    op   = word[31:26];
    a    = model_regs[word[9:5]];
    bk   = model_regs[word[14:10]];
    // 12-bit immediate in bits 21 to 10
    sext = {{20{word[21]}}, word[21:10]};
    zext = {20'd0, word[21:10]};
    shi  = word[14:10];
    case (op)
      int_exec_pkg::OP_ADD   : r = a + bk;
      int_exec_pkg::OP_SUB   : r = a - bk;
      int_exec_pkg::OP_SLT   : r = {31'd0, $signed(a) < $signed(bk)};
      int_exec_pkg::OP_SLTU  : r = {31'd0, a < bk};
      int_exec_pkg::OP_AND   : r = a & bk;
      int_exec_pkg::OP_OR    : r = a | bk;
      int_exec_pkg::OP_XOR   : r = a ^ bk;
      int_exec_pkg::OP_NOR   : r = ~(a | bk);
      int_exec_pkg::OP_SLL   : r = a << bk[4:0];
      int_exec_pkg::OP_SRL   : r = a >> bk[4:0];
      int_exec_pkg::OP_SRA   : r = $signed(a) >>> bk[4:0];
      int_exec_pkg::OP_ADDI  : r = a + sext;
      int_exec_pkg::OP_SLTI  : r = {31'd0, $signed(a) < $signed(sext)};
      int_exec_pkg::OP_SLTUI : r = {31'd0, a < sext};
      int_exec_pkg::OP_ANDI  : r = a & zext;
      int_exec_pkg::OP_ORI   : r = a | zext;
      int_exec_pkg::OP_XORI  : r = a ^ zext;
      int_exec_pkg::OP_SLLI  : r = a << shi;
      int_exec_pkg::OP_SRLI  : r = a >> shi;
      int_exec_pkg::OP_SRAI  : r = $signed(a) >>> shi;
      int_exec_pkg::OP_LUI   : r = {word[25:10], 16'd0};
      default                : r = 32'd0;
    endcase
    return r;
  endfunction

  // ======================================
  // AXI4-Lite master tasks
  // ======================================
  // Starts and ends just after a rising edge and samples on the falling edge
  task automatic axi_write(input string name, input logic [11:0] addr,
                           input logic [31:0] data, output int_exec_pkg::resp_e resp);
    int stall;
    stall = pick_stall();
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) begin
      @(negedge clk);
    end
    // AW and W accepted in the same cycle
    check_value({name, " wready"}, 32'd1, 32'(axil_rsp.wready));
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    // B must follow the accept cycle
    @(negedge clk);
    check_value({name, " bvalid"}, 32'd1, 32'(axil_rsp.bvalid));
    resp = axil_rsp.bresp;
    repeat (stall) begin
      @(negedge clk);
      check_value({name, " bvalid held"}, 32'd1, 32'(axil_rsp.bvalid));
      check_value({name, " bresp held"}, 32'(resp), 32'(axil_rsp.bresp));
    end
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.bready = 1'b1;
    @(negedge clk);
    check_value({name, " bvalid at accept"}, 32'd1, 32'(axil_rsp.bvalid));
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input string name, input logic [11:0] addr,
                          output logic [31:0] data, output int_exec_pkg::resp_e resp);
    int stall;
    stall = pick_stall();
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.arvalid = 1'b0;
    @(negedge clk);
    check_value({name, " rvalid"}, 32'd1, 32'(axil_rsp.rvalid));
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    // R payload frozen while rready stays low
    repeat (stall) begin
      @(negedge clk);
      check_value({name, " rvalid held"}, 32'd1, 32'(axil_rsp.rvalid));
      check_value({name, " rdata held"}, data, axil_rsp.rdata);
      check_value({name, " rresp held"}, 32'(resp), 32'(axil_rsp.rresp));
    end
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.rready = 1'b1;
    @(negedge clk);
    check_value({name, " rvalid at accept"}, 32'd1, 32'(axil_rsp.rvalid));
    @(posedge clk);
    #DRIVE_DELAY;
    axil_req.rready = 1'b0;
  endtask

  // ======================================
  // Instruction and readback tasks
  // ======================================
  task automatic issue_instr(input string name, input logic [31:0] word);
    logic [31:0]         result;
    int_exec_pkg::resp_e resp;
    result = model_result(word);
    axi_write(name, int_exec_pkg::ADDR_INSTR, word, resp);
    check_value({name, " bresp"}, 32'(int_exec_pkg::RESP_OKAY), 32'(resp));
    // Writes to r0 still retire
    if (word[4:0] != 5'd0) begin
      model_regs[word[4:0]] = result;
    end
    model_retired++;
  endtask

  task automatic write_expect_error(input string name, input logic [11:0] addr,
                                    input logic [31:0] word);
    int_exec_pkg::resp_e resp;
    axi_write(name, addr, word, resp);
    check_value({name, " bresp"}, 32'(int_exec_pkg::RESP_SLVERR), 32'(resp));
  endtask

  task automatic read_expect_error(input string name, input logic [11:0] addr);
    logic [31:0]         data;
    int_exec_pkg::resp_e resp;
    axi_read(name, addr, data, resp);
    check_value({name, " rresp"}, 32'(int_exec_pkg::RESP_SLVERR), 32'(resp));
    check_value({name, " rdata"}, 32'd0, data);
  endtask

  task automatic check_reg(input string name, input int idx);
    logic [31:0]         data;
    int_exec_pkg::resp_e resp;
    string               tag;
    tag = $sformatf("%s r%0d", name, idx);
    axi_read(tag, 12'(int_exec_pkg::ADDR_REG_BASE + 12'(idx * 4)), data, resp);
    check_value({tag, " rresp"}, 32'(int_exec_pkg::RESP_OKAY), 32'(resp));
    check_value(tag, model_regs[idx], data);
  endtask

  task automatic check_retired(input string name);
    logic [31:0]         data;
    int_exec_pkg::resp_e resp;
    axi_read({name, " retired"}, int_exec_pkg::ADDR_RETIRED, data, resp);
    check_value({name, " retired rresp"}, 32'(int_exec_pkg::RESP_OKAY), 32'(resp));
    check_value({name, " retired"}, 32'(model_retired), data);
  endtask

  task automatic check_all(input string name);
    for (int i = 0; i < 32; i++) begin
      check_reg(name, i);
    end
    check_retired(name);
  endtask

  // ======================================
  // Watchdog
  // ======================================
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  // ======================================
  // Main sequence
  // ======================================
  initial begin : main_seq
    int          rd;
    int          rj;
    int          rk;
    int          op;
    logic [15:0] imm;
    logic [31:0] word;
    string       name;

    clk           = 1'b0;
    arst_n        = 1'b0;
    axil_req      = '0;
    seed          = 22;
    max_stall     = 0;
    model_retired = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end

    // Outputs quiet while reset is held
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_value("reset awready", 32'd0, 32'(axil_rsp.awready));
    check_value("reset wready", 32'd0, 32'(axil_rsp.wready));
    check_value("reset arready", 32'd0, 32'(axil_rsp.arready));
    check_value("reset bvalid", 32'd0, 32'(axil_rsp.bvalid));
    check_value("reset rvalid", 32'd0, 32'(axil_rsp.rvalid));
    @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // Reset values
    check_all("reset");

    // Operand loads with r1 negative and r2 positive with shift amount 7
    for (int r = 1; r <= 8; r++) begin
      imm = 16'($random(seed));
      if (r == 1) imm[15] = 1'b1;
      if (r == 2) imm[15] = 1'b0;
      issue_instr($sformatf("load lui r%0d", r),
                  make_imm(int_exec_pkg::OP_LUI, 5'(r), 5'd0, imm));
      imm = 16'($random(seed));
      imm[11] = (r == 1 || r == 2) ? 1'b0 : imm[11];
      if (r == 2) imm[11:0] = 12'h007;
      issue_instr($sformatf("load addi r%0d", r),
                  make_imm(int_exec_pkg::OP_ADDI, 5'(r), 5'(r), imm));
      check_reg("load", r);
    end

    // Three-register ops with the first pass on r1 and r2
    for (op = 0; op <= 10; op++) begin
      for (int it = 0; it < N_RRR_ITER; it++) begin
        rj   = (it == 0) ? 1 : rand_range(1, 8);
        rk   = (it == 0) ? 2 : rand_range(1, 8);
        rd   = rand_range(9, 31);
        name = $sformatf("rrr op%0d iter%0d", op, it);
        issue_instr(name, make_rrr(6'(op), 5'(rd), 5'(rj), 5'(rk)));
        check_reg(name, rd);
      end
    end
    check_retired("rrr");

    // Immediate ops with a negative 12-bit field in the first pass
    for (op = 11; op <= 20; op++) begin
      for (int it = 0; it < N_IMM_ITER; it++) begin
        rj  = rand_range(1, 8);
        rd  = rand_range(9, 31);
        imm = 16'($random(seed));
        if (it == 0) imm[11] = 1'b1;
        if (it == 1) imm[11] = 1'b0;
        name = $sformatf("imm op%0d iter%0d", op, it);
        issue_instr(name, make_imm(6'(op), 5'(rd), 5'(rj), imm));
        check_reg(name, rd);
      end
    end

    // Writes aimed at r0 are dropped
    issue_instr("r0 addi", make_imm(int_exec_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0123));
    issue_instr("r0 lui", make_imm(int_exec_pkg::OP_LUI, 5'd0, 5'd0, 16'hbeef));
    check_reg("r0", 0);
    check_retired("imm");

    // Error responses that must not execute
    op   = rand_range(21, 63);
    word = $random(seed);
    word[31:26] = 6'(op);
    write_expect_error("illegal opcode", int_exec_pkg::ADDR_INSTR, word);
    word = make_rrr(int_exec_pkg::OP_ADD, 5'd9, 5'd1, 5'd2);
    write_expect_error("write unmapped", 12'h008, word);
    write_expect_error("write retired", int_exec_pkg::ADDR_RETIRED, word);
    write_expect_error("write reg window", 12'h084, word);
    read_expect_error("read command reg", int_exec_pkg::ADDR_INSTR);
    read_expect_error("read unmapped", 12'h008);
    read_expect_error("read below window", 12'h07c);
    read_expect_error("read misaligned", 12'h082);
    read_expect_error("read above window", 12'h100);
    check_all("after errors");

    // Random mix with B and R held back
    max_stall = 6;
    for (int i = 0; i < N_BP_INSTR; i++) begin
      op   = rand_range(0, 20);
      word = $random(seed);
      word[31:26] = 6'(op);
      issue_instr($sformatf("backpressure %0d", i), word);
    end
    check_all("backpressure");

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* int_exec_unit.f */
source/int_exec_pkg.sv
source/alu.sv
source/instr_decoder.sv
source/reg_file.sv
source/exec_pipe.sv
source/axi_lite_slave_port.sv
source/int_exec_unit.sv
bench/int_exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the integer execution unit testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert --top-module int_exec_unit_tb \
  -f int_exec_unit.f -o sim_int_exec_unit \
  && ./obj_dir/sim_int_exec_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
